/* bp_config.svh */
/*
 * branch prediction front end configuration
 * widths, counter table geometry and reset PC
 */
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// -------------------- datapath widths
`define BP_ADDR_WIDTH 32            // fetch PC and targets
`define BP_INST_WIDTH 32            // RV32 instruction word

// -------------------- counter table
`define BP_CNT_WIDTH  2             // 2-bit saturating counter
`define BP_ENTRIES    64            // counters in the table
`define BP_IDX_WIDTH  6             // index = pc[7:2]

// -------------------- fetch
`define BP_RESET_PC   32'h0000_1000 // first fetch address

`endif

/* design/bp_pkg.sv */
/*
 * branch prediction package
 * shared vector types and the named counter states
 */
`include "bp_config.svh"

package bp_pkg;

    // --------------------
    // vector types
    // --------------------
    typedef logic [`BP_ADDR_WIDTH-1:0] addr_t;    // pc or target
    typedef logic [`BP_INST_WIDTH-1:0] inst_t;    // fetched word
    typedef logic [`BP_IDX_WIDTH-1:0]  bht_idx_t; // table index
    typedef logic [`BP_CNT_WIDTH-1:0]  bht_cnt_t; // counter value

    // --------------------
    // counter states
    // --------------------
    // upper bit = taken direction, lower bit = weak/strong within side
    localparam bht_cnt_t CNT_STRONG_NT = 2'b00;
    localparam bht_cnt_t CNT_WEAK_NT   = 2'b01; // reset value
    localparam bht_cnt_t CNT_WEAK_T    = 2'b10;
    localparam bht_cnt_t CNT_STRONG_T  = 2'b11;

endpackage

/* design/bht_if.sv */
/*
 * counter table bus
 * combinational read port plus a one-strobe update port
 * between the predictor and the counter table
 */
`timescale 1ns/1ps

interface bht_if import bp_pkg::*; ();

    // read side where rd_cnt follows rd_idx in the same cycle
    bht_idx_t rd_idx;
    bht_cnt_t rd_cnt;

    // update side sampled at the rising edge
    logic     upd_valid;  // plain strobe without ack
    bht_idx_t upd_idx;
    logic     upd_taken;  // resolved direction

    // predictor side
    modport predictor (
        output rd_idx,
        input  rd_cnt,
        output upd_valid,
        output upd_idx,
        output upd_taken
    );

    // storage side
    modport tbl (
        input  rd_idx,
        output rd_cnt,
        input  upd_valid,
        input  upd_idx,
        input  upd_taken
    );

endinterface

/* design/branch_decode.sv */
/*
 * branch decoder
 * spots conditional branches and JAL, rebuilds their
 * immediates and forms the static target address
 */
`timescale 1ns/1ps

module branch_decode import bp_pkg::*; (
    input  inst_t inst_i,      // fetched word
    input  addr_t pc_i,        // address of inst_i
    output logic  is_branch_o, // beq/bne/blt/...
    output logic  is_jal_o,
    output logic  backward_o,  // negative B offset
    output addr_t target_o
);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [6:0]  opcode;
    logic [12:0] imm_b_raw; // B-type offset incl. bit 0
    logic [20:0] imm_j_raw; // J-type offset incl. bit 0
    addr_t       imm_b;
    addr_t       imm_j;

    // --------------------
    // classification
    // --------------------
    assign opcode      = inst_i[6:0];
    assign is_branch_o = (opcode == OPC_BRANCH);
    assign is_jal_o    = (opcode == OPC_JAL);

    // --------------------
    // immediates
    // --------------------
    // B imm[12|10:5] sits in 31:25 and imm[4:1|11] in 11:7
    assign imm_b_raw = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // J imm[20|10:1|11|19:12] sits in 31:12
    assign imm_j_raw = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // sign extend up to the pc width
    assign imm_b = addr_t'($signed(imm_b_raw));
    assign imm_j = addr_t'($signed(imm_j_raw));

    assign backward_o = imm_b_raw[12]; // sign bit of the B offset

    // --------------------
    // target
    // --------------------
    always_comb begin
        target_o = pc_i + addr_t'(4); // fall-through by default
        if (is_branch_o) begin
            target_o = pc_i + imm_b;
        end else if (is_jal_o) begin
            target_o = pc_i + imm_j;
        end
        // jalr and everything else keep pc + 4
    end

endmodule

/* design/bht_table.sv */
/*
 * branch history table
 * 64 two-bit saturating counters, combinational read,
 * synchronous saturating update on the update strobe
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module bht_table import bp_pkg::*; (
    input logic clk,
    input logic rst_n,
    bht_if.tbl  bht     // read + update port
);

    bht_cnt_t cnt_q [`BP_ENTRIES]; // counter array
    bht_cnt_t upd_cur;              // counter being trained
    bht_cnt_t upd_nxt;              // its next value

    // --------------------
    // read port
    // --------------------
    // a same-cycle write to this index is not forwarded so the old value is seen
    assign bht.rd_cnt = cnt_q[bht.rd_idx];

    // --------------------
    // saturating step
    // --------------------
    assign upd_cur = cnt_q[bht.upd_idx];

    always_comb begin
        upd_nxt = upd_cur;
        if (bht.upd_taken) begin
            // move up and stick at strong taken
            case (upd_cur)
                CNT_STRONG_NT: upd_nxt = CNT_WEAK_NT;
                CNT_WEAK_NT:   upd_nxt = CNT_WEAK_T;
                CNT_WEAK_T:    upd_nxt = CNT_STRONG_T;
                default:       upd_nxt = CNT_STRONG_T;
            endcase
        end else begin
            // move down and stick at strong not-taken
            case (upd_cur)
                CNT_STRONG_T:  upd_nxt = CNT_WEAK_T;
                CNT_WEAK_T:    upd_nxt = CNT_WEAK_NT;
                CNT_WEAK_NT:   upd_nxt = CNT_STRONG_NT;
                default:       upd_nxt = CNT_STRONG_NT;
            endcase
        end
    end

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                cnt_q[i] <= CNT_WEAK_NT; // no history yet
            end
        end else if (bht.upd_valid) begin
            cnt_q[bht.upd_idx] <= upd_nxt;
        end
    end

endmodule

/* design/branch_predictor.sv */
/*
 * branch predictor
 * combines decode results with the table counter into
 * the taken flag and target, and drives table updates
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module branch_predictor import bp_pkg::*; (
    input  inst_t        inst_i,
    input  logic         inst_valid_i,
    input  addr_t        pc_i,          // current fetch pc
    input  logic         stall_i,
    input  logic         upd_valid_i,   // resolved outcome from execute
    input  addr_t        upd_pc_i,
    input  logic         upd_taken_i,
    output logic         pred_taken_o,
    output addr_t        pred_target_o,
    output logic         pred_branch_o, // taken conditional branch only
    bht_if.predictor     bht
);

    logic     is_branch;
    logic     is_jal;
    logic     backward;
    bht_cnt_t cnt;
    logic     br_taken;  // direction for a conditional branch
    logic     fire;      // prediction allowed this cycle

    branch_decode u_decode (
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .backward_o  (backward),
        .target_o    (pred_target_o)
    );

    // -------------------- table access
    assign bht.rd_idx    = pc_i[`BP_IDX_WIDTH+1:2];     // word aligned pc
    assign bht.upd_valid = upd_valid_i;
    assign bht.upd_idx   = upd_pc_i[`BP_IDX_WIDTH+1:2];
    assign bht.upd_taken = upd_taken_i;
    assign cnt           = bht.rd_cnt;

    // -------------------- direction
    // taken side of the counter, or weak not-taken on a backward branch
    assign br_taken = cnt[`BP_CNT_WIDTH-1] | (cnt[0] & backward);

    assign fire = inst_valid_i & ~stall_i;

    assign pred_taken_o  = fire & ((is_branch & br_taken) | is_jal); // jal always taken
    assign pred_branch_o = fire & is_branch & br_taken;

endmodule

/* design/fetch_pc.sv */
/*
 * fetch PC register
 * next pc by priority: redirect, predicted target,
 * stall hold, then sequential pc + 4
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module fetch_pc import bp_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall_i,
    input  logic  pred_taken_i,  // already gated by stall
    input  addr_t pred_target_i,
    input  logic  redirect_i,    // mispredict from execute
    input  addr_t redirect_pc_i,
    output addr_t pc_o
);

    addr_t pc_q;
    addr_t pc_nxt;

    // -------------------- next pc
    always_comb begin
        if (redirect_i) begin
            pc_nxt = redirect_pc_i;        // wins even in a stall
        end else if (pred_taken_i) begin
            pc_nxt = pred_target_i;
        end else if (stall_i) begin
            pc_nxt = pc_q;                 // hold
        end else begin
            pc_nxt = pc_q + addr_t'(4);
        end
    end

    // -------------------- register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `BP_RESET_PC;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    assign pc_o = pc_q;

endmodule

/* design/bp_frontend_top.sv */
/*
 * branch prediction front end
 * fetch pc register, predictor and counter table
 * joined over the table bus, plain ports outside
 */
`timescale 1ns/1ps

module bp_frontend_top import bp_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    // -------------------- fetch side
    input  inst_t inst_i,        // word fetched at pc_o
    input  logic  inst_valid_i,
    input  logic  stall_i,       // freezes the front end

    // -------------------- execute side
    input  logic  upd_valid_i,   // resolved branch outcome
    input  addr_t upd_pc_i,
    input  logic  upd_taken_i,
    input  logic  redirect_i,    // one-cycle mispredict pulse
    input  addr_t redirect_pc_i,

    // -------------------- prediction
    output addr_t pc_o,
    output logic  pred_taken_o,
    output addr_t pred_target_o,
    output logic  pred_branch_o
);

    bht_if bht_bus ();  // predictor <-> table

    fetch_pc u_fetch_pc (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_i       (stall_i),
        .pred_taken_i  (pred_taken_o),  // prediction steers the pc
        .pred_target_i (pred_target_o),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (pc_o)
    );

    branch_predictor u_predictor (
        .inst_i        (inst_i),
        .inst_valid_i  (inst_valid_i),
        .pc_i          (pc_o),          // current fetch address
        .stall_i       (stall_i),
        .upd_valid_i   (upd_valid_i),
        .upd_pc_i      (upd_pc_i),
        .upd_taken_i   (upd_taken_i),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .pred_branch_o (pred_branch_o),
        .bht           (bht_bus.predictor)
    );

    bht_table u_bht (
        .clk   (clk),
        .rst_n (rst_n),
        .bht   (bht_bus.tbl)
    );

endmodule

/* bench/bp_frontend_sva.sv */
/*
 * front end assertions
 * bound onto the top level, checks prediction gating
 * and the stall hold of the fetch pc
 */
`timescale 1ns/1ps

module bp_frontend_sva import bp_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  stall_i,
    input logic  redirect_i,
    input logic  pred_taken_i,
    input logic  pred_branch_i,
    input addr_t pc_i
);

    // -------------------- prediction flags
    // a taken conditional branch is always a taken prediction
    a_branch_is_taken: assert property (
        @(posedge clk) disable iff (!rst_n)
        pred_branch_i |-> pred_taken_i
    ) else $error("pred_branch high without pred_taken");

    a_stall_blocks_taken: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_i |-> !pred_taken_i
    ) else $error("pred_taken high during a stall");

    // -------------------- pc hold
    a_stall_holds_pc: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall_i && !redirect_i) |=> (pc_i == $past(pc_i))
    ) else $error("pc moved during a stall without redirect");

endmodule

bind bp_frontend_top bp_frontend_sva u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .pred_taken_i  (pred_taken_o),
    .pred_branch_i (pred_branch_o),
    .pc_i          (pc_o)
);

/* bench/bp_frontend_tb.sv */
/*
 * front end testbench
 * directed and LCG driven stimulus, a counter table and
 * pc reference model, checks just before each rising edge
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_frontend_tb import bp_pkg::*; ();

    localparam int    NUM_CYCLES     = 400;       // random phase length
    localparam int    RESET_WAIT_MAX = 8;         // cycles
    localparam int    WATCHDOG_NS    = 20000;
    localparam [31:0] SEED           = 32'hdd0a;
    localparam int    K_BRANCH       = 0;
    localparam int    K_JAL          = 1;
    localparam int    K_OTHER        = 2;

    logic  clk;
    logic  rst_n;
    inst_t inst_i;
    logic  inst_valid_i;
    logic  stall_i;
    logic  upd_valid_i;
    addr_t upd_pc_i;
    logic  upd_taken_i;
    logic  redirect_i;
    addr_t redirect_pc_i;
    addr_t pc_o;
    logic  pred_taken_o;
    addr_t pred_target_o;
    logic  pred_branch_o;

    // reference model state
    bht_cnt_t    model_cnt [`BP_ENTRIES];
    addr_t       model_pc;
    int          kind;       // class of the word on inst_i
    addr_t       cur_off;    // its sign extended offset
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    addr_t       base_pc;
    addr_t       train_pc;

    bp_frontend_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence ended");
        $display("STATUS: FAIL");
        $finish;
    end

    // -------------------- helpers
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic bht_idx_t table_index(input addr_t pc);
        return pc[7:2];
    endfunction

    // one step toward the outcome and stuck at both ends
    function automatic bht_cnt_t train_counter(input bht_cnt_t cnt, input logic taken);
        if (taken) begin
            return (cnt == CNT_STRONG_T) ? cnt : bht_cnt_t'(cnt + 1);
        end
        return (cnt == CNT_STRONG_NT) ? cnt : bht_cnt_t'(cnt - 1);
    endfunction

    // RV32 B and J layouts
    function automatic inst_t encode_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic inst_t encode_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    task automatic load_branch(input int off);
        inst_i  = encode_branch(off[12:0]);
        kind    = K_BRANCH;
        cur_off = addr_t'(off);
    endtask

    task automatic load_jal(input int off);
        inst_i  = encode_jal(off[20:0]);
        kind    = K_JAL;
        cur_off = addr_t'(off);
    endtask

    task automatic load_other(input inst_t word);
        inst_i  = word;
        kind    = K_OTHER;
        cur_off = '0;
    endtask

    task automatic compare_bit(input string name, input string sig,
                               input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s expected %0b actual %0b at %0t", name, sig, exp, act, $time);
        end
    endtask

    task automatic compare_addr(input string name, input string sig,
                                input addr_t exp, input addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s expected %h actual %h at %0t", name, sig, exp, act, $time);
        end
    endtask

    // inputs already driven at the falling edge
    task automatic step(input string name);
        bht_cnt_t cnt;
        logic     br_taken;
        logic     fire;
        logic     exp_taken;
        logic     exp_branch;
        addr_t    exp_target;
        addr_t    next_pc;
        #1;
        cnt      = model_cnt[table_index(model_pc)];
        br_taken = (cnt == CNT_WEAK_T) || (cnt == CNT_STRONG_T)
                   || ((cnt == CNT_WEAK_NT) && cur_off[31]);  // static backward rule
        fire       = inst_valid_i && !stall_i;
        exp_taken  = fire && (((kind == K_BRANCH) && br_taken) || (kind == K_JAL));
        exp_branch = fire && (kind == K_BRANCH) && br_taken;
        exp_target = (kind == K_OTHER) ? model_pc + 32'd4 : model_pc + cur_off;
        compare_addr(name, "pc_o", model_pc, pc_o);
        compare_bit(name, "pred_taken_o", exp_taken, pred_taken_o);
        compare_bit(name, "pred_branch_o", exp_branch, pred_branch_o);
        compare_addr(name, "pred_target_o", exp_target, pred_target_o);
        if (redirect_i) begin
            next_pc = redirect_pc_i;
        end else if (exp_taken) begin
            next_pc = exp_target;
        end else if (stall_i) begin
            next_pc = model_pc;
        end else begin
            next_pc = model_pc + 32'd4;
        end
        @(posedge clk);
        model_pc = next_pc;
        if (upd_valid_i) begin
            model_cnt[table_index(upd_pc_i)] =
                train_counter(model_cnt[table_index(upd_pc_i)], upd_taken_i);
        end
        @(negedge clk);
    endtask

    // -------------------- random cycle
    task automatic drive_random(input logic lean_nt);
        logic [31:0] r;
        r = next_rand();
        case (r[31:29])  // upper lcg bits have the longest period
            3'd4:    load_jal((int'(r[14:4]) - 1024) * 2);
            3'd5:    load_other({r[31:12], 5'd1, 7'b1100111});  // jalr
            3'd6,
            3'd7:    load_other({r[31:12], 5'd3, 7'b0010011});  // addi
            default: load_branch((int'(r[8:4]) - 16) * 2);      // -32 .. +30
        endcase
        r = next_rand();
        inst_valid_i  = (r[31:29] != 3'd0);
        stall_i       = (r[28:26] == 3'd0);
        upd_valid_i   = r[25];
        upd_taken_i   = (r[24:23] != 2'd0) ^ lean_nt;
        upd_pc_i      = r[22] ? model_pc : {base_pc[31:8], r[16:11], 2'b00};
        redirect_i    = (r[20:17] == 4'd0);
        redirect_pc_i = {base_pc[31:8], r[10:5], 2'b00};
    endtask

    task automatic wait_reset_pc();
        int tries;
        tries = 0;
        while ((pc_o !== `BP_RESET_PC) && (tries < RESET_WAIT_MAX)) begin
            tries++;
            @(negedge clk);
        end
        if (pc_o !== `BP_RESET_PC) begin
            errors++;
            $display("pc_o never reached the reset PC after reset release");
        end
    endtask

    // -------------------- sequence
    initial begin
        rng_state = SEED;
        errors    = 0;
        checks    = 0;
        base_pc   = `BP_RESET_PC;
        train_pc  = base_pc + 32'h0000_0020;
        rst_n         = 1'b0;
        inst_valid_i  = 1'b0;
        stall_i       = 1'b1;   // keep pc still around reset
        upd_valid_i   = 1'b0;
        upd_pc_i      = '0;
        upd_taken_i   = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        load_other(32'h0000_0013);
        model_pc = `BP_RESET_PC;
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            model_cnt[i] = CNT_WEAK_NT;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait_reset_pc();

        // directed cases with counters still weak not-taken
        inst_valid_i = 1'b1;
        stall_i      = 1'b0;
        load_branch(16);
        step("after_reset");
        load_branch(-8);
        step("static_backward");
        load_jal(2040);
        step("jal_taken");
        load_other({20'h00000, 5'd1, 7'b1100111});
        step("jalr_not_taken");
        stall_i     = 1'b1;   // update lands while frozen
        upd_valid_i = 1'b1;
        upd_pc_i    = model_pc;
        upd_taken_i = 1'b1;
        load_jal(64);
        step("stall_gating");
        stall_i     = 1'b0;
        upd_valid_i = 1'b0;
        load_branch(16);      // same pc, counter now weak taken
        step("stall_update");
        inst_valid_i = 1'b0;
        load_branch(-4);
        step("valid_gating");
        inst_valid_i  = 1'b1;
        stall_i       = 1'b1;
        redirect_i    = 1'b1;
        redirect_pc_i = base_pc + 32'h0000_0040;
        step("redirect_in_stall");

        // train one index while redirect pins the pc to it
        stall_i = 1'b0;
        for (int i = 0; i < 48; i++) begin
            load_branch(8);
            redirect_pc_i = train_pc;
            upd_valid_i   = 1'b1;
            upd_pc_i      = train_pc;
            upd_taken_i   = ((next_rand() % 4) != 0) ^ (i >= 24);  // up then down
            step("counter_training");
        end
        redirect_i  = 1'b0;
        upd_valid_i = 1'b0;

        for (int i = 0; i < NUM_CYCLES; i++) begin
            drive_random(((i / 64) % 2) == 1);
            step("random");
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
design/bp_pkg.sv
design/bht_if.sv
design/branch_decode.sv
design/bht_table.sv
design/branch_predictor.sv
design/fetch_pc.sv
design/bp_frontend_top.sv
bench/bp_frontend_sva.sv
bench/bp_frontend_tb.sv
